// File: flist.f
+incdir+.
conv_pkg.sv
column_counter.sv
conv_ctrl.sv
tap_multiplier.sv
snake_accumulator.sv
conv_unit.sv
conv_checker.sv
tb_conv_unit.sv

// File: tb_conv_unit.sv
// convolution unit testbench
`include "conv_consts.svh"

module tb_conv_unit;

    localparam int ROWS = 5;

    logic              aclk;
    logic              reset;
    logic              aclken;
    logic              start;
    conv_pkg::kw_t     kernel_w_1;
    logic              s_valid;
    conv_pkg::pixel_t  s_data_pixels;
    conv_pkg::weight_t s_data_weights [0:`CONV_KW_MAX-1];
    logic              s_last;
    logic              s_block_last;
    logic              m_valid;
    conv_pkg::acc_t    m_data;
    logic              m_last;
    logic              flush;

    // tallies from the checker
    int mismatch_count;
    int missing_count;
    int extra_count;
    int other_count;
    int result_count;

    // per-row kernel width minus one, column count and channels per column
    int row_kw1  [0:ROWS-1];
    int row_cols [0:ROWS-1];
    int row_chan [0:ROWS-1][0:7];
    int total_beats = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    // random aclken drops and s_valid gaps
    bit stall_mode  = 1'b0;

    always #2 aclk = ~aclk;

    conv_unit uut (
        .aclk           (aclk),
        .reset          (reset),
        .aclken         (aclken),
        .start          (start),
        .kernel_w_1     (kernel_w_1),
        .s_valid        (s_valid),
        .s_data_pixels  (s_data_pixels),
        .s_data_weights (s_data_weights),
        .s_last         (s_last),
        .s_block_last   (s_block_last),
        .m_valid        (m_valid),
        .m_data         (m_data),
        .m_last         (m_last)
    );

    conv_checker u_check (
        .aclk           (aclk),
        .reset          (reset),
        .aclken         (aclken),
        .start          (start),
        .kernel_w_1     (kernel_w_1),
        .s_valid        (s_valid),
        .s_data_pixels  (s_data_pixels),
        .s_data_weights (s_data_weights),
        .s_last         (s_last),
        .s_block_last   (s_block_last),
        .m_valid        (m_valid),
        .m_data         (m_data),
        .m_last         (m_last),
        .flush          (flush),
        .mismatch_count (mismatch_count),
        .missing_count  (missing_count),
        .extra_count    (extra_count),
        .other_count    (other_count),
        .result_count   (result_count)
    );

    task automatic set_row(input int r, input int kw1, input int cols,
                           input int lo, input int hi);
        int c;
        row_kw1[r]  = kw1;
        row_cols[r] = cols;
        for (c = 0; c < cols; c++) begin
            row_chan[r][c] = $urandom_range(hi, lo);
            total_beats += row_chan[r][c];
        end
    endtask

    // drive one beat slot and repeat it while aclken is dropped
    task automatic send_cycle(input logic valid, input logic last,
                              input logic blast, input logic strt);
        logic en;
        en = 1'b0;
        while (!en) begin
            en           = !stall_mode || ($urandom_range(3, 0) != 0);
            aclken       = en;
            s_valid      = valid;
            s_last       = last;
            s_block_last = blast;
            start        = strt;
            @(posedge aclk);
            #1;
        end
    endtask

    // idle until the row's final result transfers
    task automatic wait_row_end();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            aclken       = !stall_mode || ($urandom_range(3, 0) != 0);
            s_valid      = 1'b0;
            s_last       = 1'b0;
            s_block_last = 1'b0;
            start        = 1'b0;
            seen         = m_valid && m_last && aclken;
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic run_row(input int r);
        int   c;
        int   b;
        int   k;
        logic col_end;
        kernel_w_1 = conv_pkg::kw_t'(row_kw1[r]);
        send_cycle(1'b0, 1'b0, 1'b0, 1'b1);
        // the clear cycle must not end a column
        send_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        for (c = 0; c < row_cols[r]; c++) begin
            for (b = 0; b < row_chan[r][c]; b++) begin
                if (stall_mode && $urandom_range(2, 0) == 0) begin
                    send_cycle(1'b0, 1'b0, 1'b0, 1'b0);
                end
                s_data_pixels = conv_pkg::pixel_t'($urandom);
                for (k = 0; k < `CONV_KW_MAX; k++) begin
                    s_data_weights[k] = conv_pkg::weight_t'($urandom);
                end
                col_end = (b == row_chan[r][c] - 1);
                send_cycle(1'b1, col_end, col_end && (c == row_cols[r] - 1), 1'b0);
            end
        end
        wait_row_end();
    endtask

    task automatic finish_run(input bit timed_out);
        int total;
        total = mismatch_count + missing_count + extra_count + other_count;
        $display("errors: mismatch %0d missing %0d extra %0d other %0d timeout %0d results %0d",
                 mismatch_count, missing_count, extra_count, other_count,
                 timed_out, result_count);
        if (!timed_out && total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // limit scales with the number of beats
    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            finish_run(1'b1);
        end
    end

    initial begin
        int r;
        int k;
        void'($urandom(32'h6328));
        aclk          = 1'b0;
        reset         = 1'b1;
        aclken        = 1'b1;
        start         = 1'b0;
        kernel_w_1    = '0;
        s_valid       = 1'b0;
        s_data_pixels = '0;
        for (k = 0; k < `CONV_KW_MAX; k++) begin
            s_data_weights[k] = '0;
        end
        s_last        = 1'b0;
        s_block_last  = 1'b0;
        flush         = 1'b0;
        // 3-wide, 1x1, 2-wide under stalls, then two rows back to back
        set_row(0, 2, 8, 4, 7);
        set_row(1, 0, 6, 1, 4);
        set_row(2, 1, 8, 2, 6);
        set_row(3, 2, 6, 3, 5);
        set_row(4, 1, 5, 3, 5);
        cycle_limit = 4 * total_beats + 200;
        repeat (5) @(posedge aclk);
        #1;
        reset = 1'b0;
        // outputs must stay low until the first start
        repeat (10) send_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        for (r = 0; r < ROWS; r++) begin
            stall_mode = (r == 2);
            run_row(r);
        end
        stall_mode = 1'b0;
        repeat (8) send_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        flush = 1'b1;
        send_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        flush = 1'b0;
        repeat (2) send_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        finish_run(1'b0);
    end

endmodule

// File: conv_checker.sv
// convolution result checker
`include "conv_consts.svh"

module conv_checker (
    input  logic              aclk,
    input  logic              reset,
    input  logic              aclken,
    input  logic              start,
    input  conv_pkg::kw_t     kernel_w_1,
    input  logic              s_valid,
    input  conv_pkg::pixel_t  s_data_pixels,
    input  conv_pkg::weight_t s_data_weights [0:`CONV_KW_MAX-1],
    input  logic              s_last,
    input  logic              s_block_last,
    input  logic              m_valid,
    input  conv_pkg::acc_t    m_data,
    input  logic              m_last,
    input  logic              flush,
    output int                mismatch_count,
    output int                missing_count,
    output int                extra_count,
    output int                other_count,
    output int                result_count
);

    // expected results in output order
    conv_pkg::acc_t exp_data [$];
    logic           exp_last [$];

    // accepted beats of the current row, all taps packed per beat
    conv_pkg::pixel_t                     beat_pix [$];
    logic [`CONV_KW_MAX*`CONV_DATA_W-1:0] beat_wts [$];
    int                                   beat_col [$];

    int row_kw1 = 0;
    int col_idx = 0;
    bit started = 1'b0;

    initial begin
        mismatch_count = 0;
        missing_count  = 0;
        extra_count    = 0;
        other_count    = 0;
        result_count   = 0;
    end

    // column col uses tap j on column col-kw1+j, for j = 0..kw1
    function automatic conv_pkg::acc_t column_result(input int col, input int kw1);
        int                i;
        int                j;
        int                sum;
        conv_pkg::weight_t w;
        sum = 0;
        for (i = 0; i < beat_pix.size(); i++) begin
            j = beat_col[i] - (col - kw1);
            if (j >= 0 && j <= kw1) begin
                w = beat_wts[i][j*`CONV_DATA_W +: `CONV_DATA_W];
                sum += int'(beat_pix[i]) * int'(w);
            end
        end
        // low 24 bits, same wrap as the hardware sum
        return conv_pkg::acc_t'(sum);
    endfunction

    // anything still queued never came out
    task automatic drop_pending(input string when_txt);
        if (exp_data.size() != 0) begin
            $display("%0t: %0d expected results never came out (%s)",
                     $time, exp_data.size(), when_txt);
            missing_count += exp_data.size();
        end
        exp_data.delete();
        exp_last.delete();
    endtask

    always @(posedge aclk) begin : watch
        conv_pkg::acc_t                       want;
        logic                                 want_last;
        logic [`CONV_KW_MAX*`CONV_DATA_W-1:0] wts;
        int                                   k;
        if (!reset) begin
            // outputs stay quiet until the first row
            if (!started && (m_valid || m_last)) begin
                $display("%0t: output active before any row was started", $time);
                other_count++;
            end
            // a held m_valid only counts on enabled cycles
            if (aclken && m_valid) begin
                result_count++;
                if (exp_data.size() == 0) begin
                    $display("%0t: extra result %h with nothing expected", $time, m_data);
                    extra_count++;
                end else begin
                    want      = exp_data.pop_front();
                    want_last = exp_last.pop_front();
                    if (m_data !== want) begin
                        $display("** Error m_data: expected %h, got %h at %0t",
                                 want, m_data, $time);
                        mismatch_count++;
                    end
                    if (m_last !== want_last) begin
                        $display("** Error m_last: expected %h, got %h at %0t",
                                 want_last, m_last, $time);
                        mismatch_count++;
                    end
                end
            end
            // new row, history from the last one is gone
            if (aclken && start) begin
                drop_pending("new row started");
                beat_pix.delete();
                beat_wts.delete();
                beat_col.delete();
                started = 1'b1;
                row_kw1 = kernel_w_1;
                col_idx = 0;
            end
            if (aclken && s_valid) begin
                for (k = 0; k < `CONV_KW_MAX; k++) begin
                    wts[k*`CONV_DATA_W +: `CONV_DATA_W] = s_data_weights[k];
                end
                beat_pix.push_back(s_data_pixels);
                beat_wts.push_back(wts);
                beat_col.push_back(col_idx);
                if (s_last) begin
                    // first kw1 columns only fill the carries
                    if (col_idx >= row_kw1) begin
                        exp_data.push_back(column_result(col_idx, row_kw1));
                        exp_last.push_back(s_block_last);
                    end
                    col_idx++;
                end
            end
            if (flush) begin
                drop_pending("end of test");
            end
        end
    end

endmodule

// File: conv_unit.sv
// 1-d convolution unit top level
`include "conv_consts.svh"

module conv_unit (
    input  logic              aclk,
    input  logic              reset,
    input  logic              aclken,
    input  logic              start,
    input  conv_pkg::kw_t     kernel_w_1,
    input  logic              s_valid,
    input  conv_pkg::pixel_t  s_data_pixels,
    input  conv_pkg::weight_t s_data_weights [0:`CONV_KW_MAX-1],
    input  logic              s_last,
    input  logic              s_block_last,
    output logic              m_valid,
    output conv_pkg::acc_t    m_data,
    output logic              m_last
);

    // controller outputs
    conv_pkg::kw_t kw_1;
    // row sequencing strobes
    logic          clear;
    logic          emit_en;

    // column tracking
    logic          col_done;
    logic          primed;

    // multiplier to accumulator
    conv_pkg::acc_t prod [0:`CONV_KW_MAX-1];
    logic           p_valid;
    logic           p_last;
    logic           p_block_last;

    // accumulator back to controller
    logic           row_done;

    // accepted column-end beat
    assign col_done = s_valid && aclken && s_last;

    conv_ctrl u_ctrl (
        .aclk       (aclk),
        .reset      (reset),
        .aclken     (aclken),
        .start      (start),
        .kernel_w_1 (kernel_w_1),
        .primed     (primed),
        .row_done   (row_done),
        .kw_1       (kw_1),
        .busy       (),
        .clear      (clear),
        .emit_en    (emit_en)
    );

    column_counter u_counter (
        .aclk     (aclk),
        .reset    (reset),
        .aclken   (aclken),
        .clear    (clear),
        .col_done (col_done),
        .kw_1     (kw_1),
        .primed   (primed)
    );

    tap_multiplier #(
        .MUL_DELAY (`CONV_MUL_DELAY)
    ) u_mul (
        .aclk           (aclk),
        .reset          (reset),
        .aclken         (aclken),
        .s_valid        (s_valid),
        .s_last         (s_last),
        .s_block_last   (s_block_last),
        .s_data_pixels  (s_data_pixels),
        .s_data_weights (s_data_weights),
        .prod           (prod),
        .p_valid        (p_valid),
        .p_last         (p_last),
        .p_block_last   (p_block_last)
    );

    snake_accumulator u_acc (
        .aclk         (aclk),
        .reset        (reset),
        .aclken       (aclken),
        .clear        (clear),
        .emit_en      (emit_en),
        .p_valid      (p_valid),
        .p_last       (p_last),
        .p_block_last (p_block_last),
        .prod         (prod),
        .kw_1         (kw_1),
        .m_valid      (m_valid),
        .m_last       (m_last),
        .row_done     (row_done),
        .m_data       (m_data)
    );

endmodule

// File: snake_accumulator.sv
// snaking accumulators and output register
`include "conv_consts.svh"

module snake_accumulator (
    input  logic           aclk,
    input  logic           reset,
    input  logic           aclken,
    input  logic           clear,
    input  logic           emit_en,
    input  logic           p_valid,
    input  logic           p_last,
    input  logic           p_block_last,
    input  conv_pkg::acc_t prod [0:`CONV_KW_MAX-1],
    input  conv_pkg::kw_t  kw_1,
    output logic           m_valid,
    output logic           m_last,
    output logic           row_done,
    output conv_pkg::acc_t m_data
);

    // running sum, column handoff and next sum per datapath
    conv_pkg::acc_t acc   [0:`CONV_KW_MAX-1];
    conv_pkg::acc_t carry [0:`CONV_KW_MAX-1];
    conv_pkg::acc_t sum   [0:`CONV_KW_MAX-1];

    // inside a column, past its first beat
    logic mid_col;
    // emit decision, taken once per column
    logic emit_q;
    logic col_emit;
    logic emit_now;
    // column finished last enabled cycle
    logic fin_valid;
    logic fin_last;
    logic fin_emit;

    for (genvar k = 0; k < `CONV_KW_MAX; k++) begin : g_dp
        conv_pkg::acc_t base;
        conv_pkg::acc_t acc_q;
        conv_pkg::acc_t carry_q;

        // seed for a new column
        if (k == 0) begin : g_head
            assign base = '0;
        end else begin : g_chain
            // left neighbour's sum from the previous column
            assign base = carry[k-1];
        end

        assign sum[k]   = (mid_col ? acc_q : base) + prod[k];
        assign acc[k]   = acc_q;
        assign carry[k] = carry_q;

        always_ff @(posedge aclk) begin
            if (aclken) begin
                if (p_valid) begin
                    acc_q <= sum[k];
                end
                // new row starts without history
                if (clear) begin
                    carry_q <= '0;
                end else if (p_valid && p_last) begin
                    carry_q <= sum[k];
                end
            end
        end
    end

    // a column that starts after the fill gets to emit
    // emit_q lags one cycle so the priming column is left out
    assign emit_now = mid_col ? col_emit : emit_q;

    always_ff @(posedge aclk) begin
        if (reset) begin
            mid_col   <= 1'b0;
            emit_q    <= 1'b0;
            col_emit  <= 1'b0;
            fin_valid <= 1'b0;
            fin_last  <= 1'b0;
            fin_emit  <= 1'b0;
            m_valid   <= 1'b0;
            m_last    <= 1'b0;
        end else if (aclken) begin
            emit_q <= emit_en;
            if (p_valid) begin
                mid_col <= !p_last;
                if (!mid_col) begin
                    col_emit <= emit_q;
                end
            end
            // accumulate stage done
            fin_valid <= p_valid && p_last;
            fin_last  <= p_valid && p_last && p_block_last;
            fin_emit  <= emit_now;
            // output stage
            m_valid   <= fin_valid && fin_emit;
            m_last    <= fin_valid && fin_emit && fin_last;
        end
    end

    // rightmost active datapath holds the full kernel sum
    always_ff @(posedge aclk) begin
        if (aclken && fin_valid && fin_emit) begin
            m_data <= acc[kw_1];
        end
    end

    // final column of the row has been summed
    assign row_done = fin_last;

    a_emit_gated : assert property (
        @(posedge aclk) disable iff (reset)
        $rose(m_valid) |-> $past(emit_en)
    ) else $error("snake_accumulator: result emitted outside RUN");

endmodule

// File: tap_multiplier.sv
// per-tap multiplier pipeline
`include "conv_consts.svh"

module tap_multiplier #(
    parameter int MUL_DELAY = `CONV_MUL_DELAY
) (
    input  logic              aclk,
    input  logic              reset,
    input  logic              aclken,
    input  logic              s_valid,
    input  logic              s_last,
    input  logic              s_block_last,
    input  conv_pkg::pixel_t  s_data_pixels,
    input  conv_pkg::weight_t s_data_weights [0:`CONV_KW_MAX-1],
    output conv_pkg::acc_t    prod [0:`CONV_KW_MAX-1],
    output logic              p_valid,
    output logic              p_last,
    output logic              p_block_last
);

    // full-width products before the first stage
    conv_pkg::acc_t mul_in [0:`CONV_KW_MAX-1];

    // product stages, one row of taps per stage
    conv_pkg::acc_t prod_pipe [0:MUL_DELAY-1][0:`CONV_KW_MAX-1];

    // beat flags kept in step with the products
    logic [MUL_DELAY-1:0] valid_pipe;
    logic [MUL_DELAY-1:0] last_pipe;
    logic [MUL_DELAY-1:0] block_last_pipe;

    // same pixel against every tap
    // sign extension first, so the wrap matches the accumulator
    for (genvar k = 0; k < `CONV_KW_MAX; k++) begin : g_tap
        assign mul_in[k] = conv_pkg::acc_t'(s_data_pixels)
                         * conv_pkg::acc_t'(s_data_weights[k]);
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            prod_pipe[0] <= mul_in;
            for (int s = 1; s < MUL_DELAY; s++) begin
                prod_pipe[s] <= prod_pipe[s-1];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_pipe      <= '0;
            last_pipe       <= '0;
            block_last_pipe <= '0;
        end else if (aclken) begin
            valid_pipe[0]      <= s_valid;
            last_pipe[0]       <= s_last;
            block_last_pipe[0] <= s_block_last;
            for (int s = 1; s < MUL_DELAY; s++) begin
                valid_pipe[s]      <= valid_pipe[s-1];
                last_pipe[s]       <= last_pipe[s-1];
                block_last_pipe[s] <= block_last_pipe[s-1];
            end
        end
    end

    // last stage drives the accumulator
    assign prod         = prod_pipe[MUL_DELAY-1];
    assign p_valid      = valid_pipe[MUL_DELAY-1];
    assign p_last       = last_pipe[MUL_DELAY-1];
    assign p_block_last = block_last_pipe[MUL_DELAY-1];

    a_p_valid_known : assert property (
        @(posedge aclk) disable iff (reset)
        !$isunknown(p_valid)
    ) else $error("tap_multiplier: p_valid is unknown");

endmodule

// File: conv_ctrl.sv
// row controller
`include "conv_consts.svh"

module conv_ctrl (
    input  logic          aclk,
    input  logic          reset,
    input  logic          aclken,
    input  logic          start,
    input  conv_pkg::kw_t kernel_w_1,
    input  logic          primed,
    input  logic          row_done,
    output conv_pkg::kw_t kw_1,
    output logic          busy,
    output logic          clear,
    output logic          emit_en
);

    conv_pkg::ctrl_state_e state;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= conv_pkg::IDLE;
            kw_1  <= '0;
            clear <= 1'b0;
        end else if (aclken) begin
            // clear is a single enabled-cycle strobe
            clear <= 1'b0;
            case (state)
                conv_pkg::IDLE: begin
                    // new row, hold the kernel width for the whole row
                    if (start) begin
                        state <= conv_pkg::FILL;
                        kw_1  <= kernel_w_1;
                        clear <= 1'b1;
                    end
                end
                conv_pkg::FILL: begin
                    // wait for the first kw_1 columns to seed the carries
                    if (primed) begin
                        state <= conv_pkg::RUN;
                    end
                end
                conv_pkg::RUN: begin
                    // last column of the row has been summed
                    if (row_done) begin
                        state <= conv_pkg::IDLE;
                    end
                end
                default: begin
                    state <= conv_pkg::IDLE;
                end
            endcase
        end
    end

    // status outputs straight from the state
    assign busy    = (state != conv_pkg::IDLE);
    assign emit_en = (state == conv_pkg::RUN);

    // the accumulator picks its output datapath with kw_1
    a_kw_in_range : assert property (
        @(posedge aclk) disable iff (reset)
        busy |-> (kw_1 < `CONV_KW_MAX)
    ) else $error("conv_ctrl: kernel width %0d exceeds datapaths", kw_1 + 1);

endmodule

// File: column_counter.sv
// finished column counter
module column_counter (
    input  logic          aclk,
    input  logic          reset,
    input  logic          aclken,
    input  logic          clear,
    input  logic          col_done,
    input  conv_pkg::kw_t kw_1,
    output logic          primed
);

    // columns completed since the row started, saturates at kw_1
    conv_pkg::kw_t count;

    always_ff @(posedge aclk) begin
        if (reset) begin
            count <= '0;
        end else if (aclken) begin
            if (clear) begin
                count <= '0;
            end else if (col_done && (count < kw_1)) begin
                count <= count + 2'd1;
            end
        end
    end

    // count still holds the previous row during clear
    // 1x1 needs no history, so it is primed straight away
    assign primed = clear ? (kw_1 == '0) : (count >= kw_1);

    // a row must not finish a column on the cycle it is cleared
    a_no_col_during_clear : assert property (
        @(posedge aclk) disable iff (reset)
        (aclken && clear) |-> !col_done
    ) else $error("column_counter: col_done while clear is high");

endmodule

// File: conv_pkg.sv
// convolution unit types
`include "conv_consts.svh"

package conv_pkg;

    // signed input pixel
    typedef logic signed [`CONV_DATA_W-1:0] pixel_t;

    // signed kernel tap
    typedef logic signed [`CONV_DATA_W-1:0] weight_t;

    // wrapping partial and final sum
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    // kernel width minus one
    typedef logic [1:0] kw_t;

    // row sequencing
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        RUN
    } ctrl_state_e;

endpackage

// File: conv_consts.svh
// convolution unit constants
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// pixel and weight width
`define CONV_DATA_W 8

// accumulator and result width, sums wrap here
`define CONV_ACC_W 24

// datapath count and largest kernel width
`define CONV_KW_MAX 3

// multiplier pipeline depth in enabled cycles
`define CONV_MUL_DELAY 2

`endif
